//--- include/mmu_cfg.svh
// MMU configuration
// Address widths, TLB size and the APB register map of the data-side MMU
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

`define MMU_VADDR_WIDTH       32
`define MMU_PADDR_WIDTH       34
`define MMU_PAGE_OFFSET_WIDTH 12
`define MMU_TLB_ENTRIES       8
`define MMU_APB_ADDR_WIDTH    8
`define MMU_APB_DATA_WIDTH    32

// APB register offsets
`define MMU_REG_CTRL      8'h00
`define MMU_REG_FILL_VTAG 8'h04
`define MMU_REG_FILL_PTE  8'h08
`define MMU_REG_CMD       8'h0C

// CTRL fields
`define MMU_CTRL_EN_BIT   0
`define MMU_CTRL_PRIV_LSB 1
`define MMU_CTRL_SUM_BIT  3

// FILL_PTE fields
`define MMU_PTE_PTAG_LSB 0
`define MMU_PTE_U_BIT    24
`define MMU_PTE_W_BIT    25
`define MMU_PTE_D_BIT    26

// CMD fields
`define MMU_CMD_FILL_BIT  0
`define MMU_CMD_FLUSH_BIT 1

`endif

//--- rtl/mmu_pkg.sv
// MMU types
// Vector types for addresses, tags and APB fields, plus the privilege mode
package mmu_pkg;

  `include "mmu_cfg.svh"

  localparam int unsigned TLB_ENTRIES       = `MMU_TLB_ENTRIES;
  localparam int unsigned PAGE_OFFSET_WIDTH = `MMU_PAGE_OFFSET_WIDTH;

  typedef logic [`MMU_VADDR_WIDTH-1:0] vaddr_t;
  typedef logic [`MMU_PADDR_WIDTH-1:0] paddr_t;

  // Page numbers
  typedef logic [`MMU_VADDR_WIDTH-`MMU_PAGE_OFFSET_WIDTH-1:0] vtag_t;
  typedef logic [`MMU_PADDR_WIDTH-`MMU_PAGE_OFFSET_WIDTH-1:0] ptag_t;
  typedef logic [`MMU_PAGE_OFFSET_WIDTH-1:0] page_offset_t;

  typedef logic [$clog2(`MMU_TLB_ENTRIES)-1:0] entry_idx_t;

  typedef logic [`MMU_APB_ADDR_WIDTH-1:0] apb_addr_t;
  typedef logic [`MMU_APB_DATA_WIDTH-1:0] apb_data_t;

  // Encoding 2 is reserved
  typedef enum logic [1:0] {
    PRIV_USER       = 2'd0,
    PRIV_SUPERVISOR = 2'd1,
    PRIV_MACHINE    = 2'd3
  } priv_mode_e;

endpackage

//--- rtl/mmu_apb_regs.sv
// MMU APB register block
// Holds translation control and the TLB fill staging registers, and turns
// writes to the command register into one-cycle fill and flush pulses
`timescale 1ns/10ps
`include "mmu_cfg.svh"

module mmu_apb_regs (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  mmu_pkg::apb_addr_t    paddr_i,
  input  mmu_pkg::apb_data_t    pwdata_i,
  output mmu_pkg::apb_data_t    prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  output logic                  translation_en_o,
  output mmu_pkg::priv_mode_e   priv_mode_o,
  output logic                  sum_o,
  output logic                  fill_v_o,
  output logic                  flush_v_o,
  output mmu_pkg::vtag_t        fill_vtag_o,
  output mmu_pkg::ptag_t        fill_ptag_o,
  output logic                  fill_u_o,
  output logic                  fill_w_o,
  output logic                  fill_d_o
);

  logic               access;
  logic               addr_valid;
  logic               wr_en;
  mmu_pkg::apb_data_t rdata;

  assign access     = psel_i & penable_i;
  assign addr_valid = paddr_i inside {`MMU_REG_CTRL, `MMU_REG_FILL_VTAG,
                                      `MMU_REG_FILL_PTE, `MMU_REG_CMD};
  assign wr_en      = access & pwrite_i & addr_valid;

  // Zero wait states
  assign pready_o  = 1'b1;
  assign pslverr_o = access & ~addr_valid;

  // Control register and command pulses
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      translation_en_o <= 1'b0;
      priv_mode_o      <= mmu_pkg::PRIV_USER;
      sum_o            <= 1'b0;
      fill_v_o         <= 1'b0;
      flush_v_o        <= 1'b0;
    end else begin
      fill_v_o  <= 1'b0;
      flush_v_o <= 1'b0;
      if (wr_en && paddr_i == `MMU_REG_CTRL) begin
        translation_en_o <= pwdata_i[`MMU_CTRL_EN_BIT];
        priv_mode_o      <= mmu_pkg::priv_mode_e'(pwdata_i[`MMU_CTRL_PRIV_LSB +: 2]);
        sum_o            <= pwdata_i[`MMU_CTRL_SUM_BIT];
      end
      if (wr_en && paddr_i == `MMU_REG_CMD) begin
        fill_v_o  <= pwdata_i[`MMU_CMD_FILL_BIT];
        flush_v_o <= pwdata_i[`MMU_CMD_FLUSH_BIT];
      end
    end
  end

  // Fill staging
  always_ff @(posedge clk_i) begin
    if (wr_en && paddr_i == `MMU_REG_FILL_VTAG) begin
      fill_vtag_o <= pwdata_i[$bits(mmu_pkg::vtag_t)-1:0];
    end
    if (wr_en && paddr_i == `MMU_REG_FILL_PTE) begin
      fill_ptag_o <= pwdata_i[`MMU_PTE_PTAG_LSB +: $bits(mmu_pkg::ptag_t)];
      fill_u_o    <= pwdata_i[`MMU_PTE_U_BIT];
      fill_w_o    <= pwdata_i[`MMU_PTE_W_BIT];
      fill_d_o    <= pwdata_i[`MMU_PTE_D_BIT];
    end
  end

  // CMD and unknown offsets read as zero
  always_comb begin
    rdata = '0;
    case (paddr_i)
      `MMU_REG_CTRL: begin
        rdata[`MMU_CTRL_EN_BIT]          = translation_en_o;
        rdata[`MMU_CTRL_PRIV_LSB +: 2]   = priv_mode_o;
        rdata[`MMU_CTRL_SUM_BIT]         = sum_o;
      end
      `MMU_REG_FILL_VTAG: begin
        rdata[$bits(mmu_pkg::vtag_t)-1:0] = fill_vtag_o;
      end
      `MMU_REG_FILL_PTE: begin
        rdata[`MMU_PTE_PTAG_LSB +: $bits(mmu_pkg::ptag_t)] = fill_ptag_o;
        rdata[`MMU_PTE_U_BIT] = fill_u_o;
        rdata[`MMU_PTE_W_BIT] = fill_w_o;
        rdata[`MMU_PTE_D_BIT] = fill_d_o;
      end
      default: rdata = '0;
    endcase
  end

  assign prdata_o = rdata;

endmodule

//--- rtl/mmu_cmd_stage.sv
// MMU command stage
// First pipeline register for load and store commands, and the round-robin
// victim pointer that picks which TLB entry a fill overwrites
`timescale 1ns/10ps

module mmu_cmd_stage (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              cmd_v_i,
  input  logic                              cmd_store_i,
  input  mmu_pkg::vaddr_t                   cmd_vaddr_i,
  input  logic                              fill_v_i,
  output logic                              s1_v_o,
  output logic                              s1_store_o,
  output mmu_pkg::vaddr_t                   s1_vaddr_o,
  output logic [mmu_pkg::TLB_ENTRIES-1:0]   entry_we_o
);

  mmu_pkg::entry_idx_t victim_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v_o <= 1'b0;
    end else begin
      s1_v_o <= cmd_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_store_o <= cmd_store_i;
    s1_vaddr_o <= cmd_vaddr_i;
  end

  // Wraps after the last entry
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      victim_r <= '0;
    end else if (fill_v_i) begin
      victim_r <= victim_r + 1'b1;
    end
  end

  // One-hot write enable for the victim
  always_comb begin
    entry_we_o = '0;
    for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
      if (fill_v_i && victim_r == mmu_pkg::entry_idx_t'(i)) begin
        entry_we_o[i] = 1'b1;
      end
    end
  end

endmodule

//--- rtl/mmu_tlb_entry.sv
// TLB entry
// One fully associative slot: valid bit, virtual tag and leaf PTE fields,
// with a combinational tag compare against the lookup tag
`timescale 1ns/10ps

module mmu_tlb_entry (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            flush_i,
  input  logic            we_i,
  input  mmu_pkg::vtag_t  w_vtag_i,
  input  mmu_pkg::ptag_t  w_ptag_i,
  input  logic            w_u_i,
  input  logic            w_w_i,
  input  logic            w_d_i,
  input  mmu_pkg::vtag_t  lookup_vtag_i,
  output logic            hit_o,
  output mmu_pkg::ptag_t  ptag_o,
  output logic            u_o,
  output logic            w_o,
  output logic            d_o
);

  logic           valid_r;
  mmu_pkg::vtag_t vtag_r;

  // A fill in the same cycle as a flush wins
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= 1'b0;
    end else if (we_i) begin
      valid_r <= 1'b1;
    end else if (flush_i) begin
      valid_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      vtag_r <= w_vtag_i;
      ptag_o <= w_ptag_i;
      u_o    <= w_u_i;
      w_o    <= w_w_i;
      d_o    <= w_d_i;
    end
  end

  assign hit_o = valid_r & (vtag_r == lookup_vtag_i);

endmodule

//--- rtl/mmu_resp_stage.sv
// MMU response stage
// Selects the hitting TLB entry, applies the page-fault rules, forms the
// physical address and registers the response for the consumer
`timescale 1ns/10ps

module mmu_resp_stage (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             s1_v_i,
  input  logic                             s1_store_i,
  input  mmu_pkg::vaddr_t                  s1_vaddr_i,
  input  logic                             kill_i,
  input  logic                             translation_en_i,
  input  mmu_pkg::priv_mode_e              priv_mode_i,
  input  logic                             sum_i,
  input  logic [mmu_pkg::TLB_ENTRIES-1:0]  hit_i,
  input  mmu_pkg::ptag_t                   entry_ptag_i [mmu_pkg::TLB_ENTRIES],
  input  logic [mmu_pkg::TLB_ENTRIES-1:0]  entry_u_i,
  input  logic [mmu_pkg::TLB_ENTRIES-1:0]  entry_w_i,
  input  logic [mmu_pkg::TLB_ENTRIES-1:0]  entry_d_i,
  output logic                             resp_v_o,
  output logic                             resp_tlb_miss_o,
  output logic                             resp_load_fault_o,
  output logic                             resp_store_fault_o,
  output mmu_pkg::paddr_t                  resp_paddr_o
);

  logic                  hit_any;
  mmu_pkg::ptag_t        sel_ptag;
  logic                  sel_u;
  logic                  sel_w;
  logic                  sel_d;
  mmu_pkg::page_offset_t page_offset;
  logic                  priv_fault;
  logic                  write_fault;
  logic                  tlb_miss;
  logic                  load_fault;
  logic                  store_fault;
  mmu_pkg::paddr_t       paddr;

  assign page_offset = s1_vaddr_i[mmu_pkg::PAGE_OFFSET_WIDTH-1:0];

  // Walk downward so the lowest index hit is the one kept
  always_comb begin
    hit_any  = 1'b0;
    sel_ptag = '0;
    sel_u    = 1'b0;
    sel_w    = 1'b0;
    sel_d    = 1'b0;
    for (int i = mmu_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
      if (hit_i[i]) begin
        hit_any  = 1'b1;
        sel_ptag = entry_ptag_i[i];
        sel_u    = entry_u_i[i];
        sel_w    = entry_w_i[i];
        sel_d    = entry_d_i[i];
      end
    end
  end

  // Machine mode is exempt
  assign priv_fault  = ((priv_mode_i == mmu_pkg::PRIV_SUPERVISOR) & ~sum_i & sel_u)
                     | ((priv_mode_i == mmu_pkg::PRIV_USER) & ~sel_u);
  assign write_fault = ~sel_w | ~sel_d;

  always_comb begin
    tlb_miss    = 1'b0;
    load_fault  = 1'b0;
    store_fault = 1'b0;
    paddr       = '0;
    if (!translation_en_i) begin
      paddr = mmu_pkg::paddr_t'(s1_vaddr_i);
    end else if (!hit_any) begin
      tlb_miss = 1'b1;
    end else begin
      paddr       = {sel_ptag, page_offset};
      load_fault  = ~s1_store_i & priv_fault;
      store_fault = s1_store_i & (priv_fault | write_fault);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_o           <= 1'b0;
      resp_tlb_miss_o    <= 1'b0;
      resp_load_fault_o  <= 1'b0;
      resp_store_fault_o <= 1'b0;
    end else begin
      resp_v_o           <= s1_v_i & ~kill_i;
      resp_tlb_miss_o    <= tlb_miss;
      resp_load_fault_o  <= load_fault;
      resp_store_fault_o <= store_fault;
    end
  end

  always_ff @(posedge clk_i) begin
    resp_paddr_o <= paddr;
  end

endmodule

//--- rtl/mmu_top.sv
// Data-side MMU top level
// Two-stage address translation: command register, fully associative TLB
// lookup and registered response, with an APB slave for control and fills
`timescale 1ns/10ps

module mmu_top (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  mmu_pkg::apb_addr_t  paddr_i,
  input  mmu_pkg::apb_data_t  pwdata_i,
  output mmu_pkg::apb_data_t  prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  input  logic                cmd_v_i,
  input  logic                cmd_store_i,
  input  mmu_pkg::vaddr_t     cmd_vaddr_i,
  input  logic                kill_i,
  output logic                resp_v_o,
  output logic                resp_tlb_miss_o,
  output logic                resp_load_fault_o,
  output logic                resp_store_fault_o,
  output mmu_pkg::paddr_t     resp_paddr_o
);

  logic                             translation_en;
  mmu_pkg::priv_mode_e              priv_mode;
  logic                             sum;
  logic                             fill_v;
  logic                             flush_v;
  mmu_pkg::vtag_t                   fill_vtag;
  mmu_pkg::ptag_t                   fill_ptag;
  logic                             fill_u;
  logic                             fill_w;
  logic                             fill_d;

  logic                             s1_v;
  logic                             s1_store;
  mmu_pkg::vaddr_t                  s1_vaddr;
  logic [mmu_pkg::TLB_ENTRIES-1:0]  entry_we;

  logic [mmu_pkg::TLB_ENTRIES-1:0]  entry_hit;
  mmu_pkg::ptag_t                   entry_ptag [mmu_pkg::TLB_ENTRIES];
  logic [mmu_pkg::TLB_ENTRIES-1:0]  entry_u;
  logic [mmu_pkg::TLB_ENTRIES-1:0]  entry_w;
  logic [mmu_pkg::TLB_ENTRIES-1:0]  entry_d;

  mmu_apb_regs apb_regs_inst (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .psel_i(psel_i),
    .penable_i(penable_i),
    .pwrite_i(pwrite_i),
    .paddr_i(paddr_i),
    .pwdata_i(pwdata_i),
    .prdata_o(prdata_o),
    .pready_o(pready_o),
    .pslverr_o(pslverr_o),
    .translation_en_o(translation_en),
    .priv_mode_o(priv_mode),
    .sum_o(sum),
    .fill_v_o(fill_v),
    .flush_v_o(flush_v),
    .fill_vtag_o(fill_vtag),
    .fill_ptag_o(fill_ptag),
    .fill_u_o(fill_u),
    .fill_w_o(fill_w),
    .fill_d_o(fill_d)
  );

  mmu_cmd_stage cmd_stage_inst (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .cmd_v_i(cmd_v_i),
    .cmd_store_i(cmd_store_i),
    .cmd_vaddr_i(cmd_vaddr_i),
    .fill_v_i(fill_v),
    .s1_v_o(s1_v),
    .s1_store_o(s1_store),
    .s1_vaddr_o(s1_vaddr),
    .entry_we_o(entry_we)
  );

  for (genvar i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin : g_entry
    mmu_tlb_entry tlb_entry_inst (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .flush_i(flush_v),
      .we_i(entry_we[i]),
      .w_vtag_i(fill_vtag),
      .w_ptag_i(fill_ptag),
      .w_u_i(fill_u),
      .w_w_i(fill_w),
      .w_d_i(fill_d),
      .lookup_vtag_i(s1_vaddr[$bits(mmu_pkg::vaddr_t)-1:mmu_pkg::PAGE_OFFSET_WIDTH]),
      .hit_o(entry_hit[i]),
      .ptag_o(entry_ptag[i]),
      .u_o(entry_u[i]),
      .w_o(entry_w[i]),
      .d_o(entry_d[i])
    );
  end

  mmu_resp_stage resp_stage_inst (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .s1_v_i(s1_v),
    .s1_store_i(s1_store),
    .s1_vaddr_i(s1_vaddr),
    .kill_i(kill_i),
    .translation_en_i(translation_en),
    .priv_mode_i(priv_mode),
    .sum_i(sum),
    .hit_i(entry_hit),
    .entry_ptag_i(entry_ptag),
    .entry_u_i(entry_u),
    .entry_w_i(entry_w),
    .entry_d_i(entry_d),
    .resp_v_o(resp_v_o),
    .resp_tlb_miss_o(resp_tlb_miss_o),
    .resp_load_fault_o(resp_load_fault_o),
    .resp_store_fault_o(resp_store_fault_o),
    .resp_paddr_o(resp_paddr_o)
  );

endmodule

//--- testbench/mmu_tb.sv
// MMU testbench
// Directed tests for the data-side MMU: APB registers, bypass, TLB hits and
// misses, the page-fault table, round-robin eviction, flush and kill
`timescale 1ns/10ps
`include "mmu_cfg.svh"

module mmu_tb;

  localparam int ENTRIES = `MMU_TLB_ENTRIES;
  // Tests take about 400 cycles, so this leaves a wide margin
  localparam int TIMEOUT_NS = 20000;

  logic                clk_i;
  logic                reset_i;
  logic                psel_i;
  logic                penable_i;
  logic                pwrite_i;
  mmu_pkg::apb_addr_t  paddr_i;
  mmu_pkg::apb_data_t  pwdata_i;
  mmu_pkg::apb_data_t  prdata_o;
  logic                pready_o;
  logic                pslverr_o;
  logic                cmd_v_i;
  logic                cmd_store_i;
  mmu_pkg::vaddr_t     cmd_vaddr_i;
  logic                kill_i;
  logic                resp_v_o;
  logic                resp_tlb_miss_o;
  logic                resp_load_fault_o;
  logic                resp_store_fault_o;
  mmu_pkg::paddr_t     resp_paddr_o;

  int seed = 50;
  int errors = 0;
  int checks = 0;

  // Reference state of control and TLB
  logic                model_en;
  mmu_pkg::priv_mode_e model_priv;
  logic                model_sum;
  logic                model_valid [ENTRIES];
  mmu_pkg::vtag_t      model_vtag [ENTRIES];
  mmu_pkg::ptag_t      model_ptag [ENTRIES];
  logic                model_u [ENTRIES];
  logic                model_w [ENTRIES];
  logic                model_d [ENTRIES];
  int                  model_victim;

  mmu_top mmu_top_inst (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .psel_i(psel_i),
    .penable_i(penable_i),
    .pwrite_i(pwrite_i),
    .paddr_i(paddr_i),
    .pwdata_i(pwdata_i),
    .prdata_o(prdata_o),
    .pready_o(pready_o),
    .pslverr_o(pslverr_o),
    .cmd_v_i(cmd_v_i),
    .cmd_store_i(cmd_store_i),
    .cmd_vaddr_i(cmd_vaddr_i),
    .kill_i(kill_i),
    .resp_v_o(resp_v_o),
    .resp_tlb_miss_o(resp_tlb_miss_o),
    .resp_load_fault_o(resp_load_fault_o),
    .resp_store_fault_o(resp_store_fault_o),
    .resp_paddr_o(resp_paddr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Testbench failed");
    $finish;
  end

  task automatic check_bit(input string name, input logic actual, input logic expected);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Fail at %0t: %s is %b, expected %b", $time, name, actual, expected);
    end
  endtask

  task automatic check_vec(input string name, input logic [33:0] actual,
                           input logic [33:0] expected);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // All bus tasks start and end 1 ns after a rising edge
  task automatic apb_access(input logic write, input mmu_pkg::apb_addr_t addr,
                            input mmu_pkg::apb_data_t wdata,
                            output mmu_pkg::apb_data_t rdata, output logic err);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(posedge clk_i);
    #1;
    penable_i = 1'b1;
    @(negedge clk_i);
    rdata = prdata_o;
    err   = pslverr_o;
    check_bit("pready_o", pready_o, 1'b1);
    @(posedge clk_i);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_write(input mmu_pkg::apb_addr_t addr, input mmu_pkg::apb_data_t data,
                           input logic exp_err);
    mmu_pkg::apb_data_t rd;
    logic err;
    apb_access(1'b1, addr, data, rd, err);
    check_bit("pslverr_o", err, exp_err);
  endtask

  task automatic apb_read(input mmu_pkg::apb_addr_t addr, input mmu_pkg::apb_data_t exp_data,
                          input logic exp_err);
    mmu_pkg::apb_data_t rd;
    logic err;
    apb_access(1'b0, addr, '0, rd, err);
    check_bit("pslverr_o", err, exp_err);
    check_vec("prdata_o", {2'b00, rd}, {2'b00, exp_data});
  endtask

  task automatic set_ctrl(input logic en, input mmu_pkg::priv_mode_e priv, input logic sum);
    apb_write(`MMU_REG_CTRL, {28'd0, sum, priv, en}, 1'b0);
    model_en   = en;
    model_priv = priv;
    model_sum  = sum;
  endtask

  task automatic tlb_fill(input mmu_pkg::vtag_t vtag, input mmu_pkg::ptag_t ptag,
                          input logic u, input logic w, input logic d);
    mmu_pkg::apb_data_t pte;
    pte = '0;
    pte[21:0] = ptag;
    pte[`MMU_PTE_U_BIT] = u;
    pte[`MMU_PTE_W_BIT] = w;
    pte[`MMU_PTE_D_BIT] = d;
    apb_write(`MMU_REG_FILL_VTAG, {12'd0, vtag}, 1'b0);
    apb_write(`MMU_REG_FILL_PTE, pte, 1'b0);
    apb_write(`MMU_REG_CMD, 32'h1, 1'b0);
    // The pulse comes in the next cycle and the entry is written at the edge after
    repeat (2) @(posedge clk_i);
    #1;
    model_valid[model_victim] = 1'b1;
    model_vtag[model_victim]  = vtag;
    model_ptag[model_victim]  = ptag;
    model_u[model_victim]     = u;
    model_w[model_victim]     = w;
    model_d[model_victim]     = d;
    model_victim = (model_victim + 1) % ENTRIES;
  endtask

  task automatic tlb_flush();
    apb_write(`MMU_REG_CMD, 32'h2, 1'b0);
    repeat (2) @(posedge clk_i);
    #1;
    for (int i = 0; i < ENTRIES; i++) begin
      model_valid[i] = 1'b0;
    end
  endtask

  // Expected response from the translation and page-fault rules
  task automatic predict(input logic store, input mmu_pkg::vaddr_t va, output logic miss,
                         output logic lf, output logic sf, output mmu_pkg::paddr_t pa);
    int   hit_idx;
    logic perm_fault;
    hit_idx = -1;
    perm_fault = 1'b0;
    miss = 1'b0;
    lf = 1'b0;
    sf = 1'b0;
    pa = '0;
    for (int i = ENTRIES - 1; i >= 0; i--) begin
      if (model_valid[i] && model_vtag[i] == va[31:12]) begin
        hit_idx = i;
      end
    end
    if (!model_en) begin
      pa = {2'b00, va};
    end else if (hit_idx < 0) begin
      miss = 1'b1;
    end else begin
      pa = {model_ptag[hit_idx], va[11:0]};
      if (model_priv == mmu_pkg::PRIV_SUPERVISOR && !model_sum && model_u[hit_idx])
        perm_fault = 1'b1;
      if (model_priv == mmu_pkg::PRIV_USER && !model_u[hit_idx])
        perm_fault = 1'b1;
      if (store) begin
        sf = perm_fault | !(model_w[hit_idx] && model_d[hit_idx]);
      end else begin
        lf = perm_fault;
      end
    end
  endtask

  task automatic check_resp(input logic exp_v, input logic exp_miss, input logic exp_lf,
                            input logic exp_sf, input mmu_pkg::paddr_t exp_pa);
    check_bit("resp_v_o", resp_v_o, exp_v);
    if (exp_v) begin
      check_bit("resp_tlb_miss_o", resp_tlb_miss_o, exp_miss);
      check_bit("resp_load_fault_o", resp_load_fault_o, exp_lf);
      check_bit("resp_store_fault_o", resp_store_fault_o, exp_sf);
      check_vec("resp_paddr_o", resp_paddr_o, exp_pa);
    end
  endtask

  task automatic send_cmd(input logic store, input mmu_pkg::vaddr_t va);
    logic miss;
    logic lf;
    logic sf;
    mmu_pkg::paddr_t pa;
    predict(store, va, miss, lf, sf, pa);
    cmd_v_i     = 1'b1;
    cmd_store_i = store;
    cmd_vaddr_i = va;
    @(posedge clk_i);
    #1;
    cmd_v_i = 1'b0;
    @(posedge clk_i);
    #1;
    check_resp(1'b1, miss, lf, sf, pa);
  endtask

  task automatic test_registers();
    apb_write(`MMU_REG_CTRL, 32'h0000_000B, 1'b0);
    apb_read(`MMU_REG_CTRL, 32'h0000_000B, 1'b0);
    apb_write(`MMU_REG_FILL_VTAG, 32'hFFFA_BCDE, 1'b0);
    apb_read(`MMU_REG_FILL_VTAG, 32'h000A_BCDE, 1'b0);
    // Only ptag, U, W and D are stored
    apb_write(`MMU_REG_FILL_PTE, 32'hFFFF_FFFF, 1'b0);
    apb_read(`MMU_REG_FILL_PTE, 32'h073F_FFFF, 1'b0);
    apb_read(`MMU_REG_CMD, 32'h0, 1'b0);
    apb_write(8'h10, 32'hFFFF_FFFF, 1'b1);
    apb_read(8'h10, 32'h0, 1'b1);
    apb_read(`MMU_REG_CTRL, 32'h0000_000B, 1'b0);
    apb_read(`MMU_REG_FILL_VTAG, 32'h000A_BCDE, 1'b0);
    apb_read(`MMU_REG_FILL_PTE, 32'h073F_FFFF, 1'b0);
  endtask

  task automatic test_bypass();
    mmu_pkg::vaddr_t va;
    logic [31:0] rnd;
    set_ctrl(1'b0, mmu_pkg::PRIV_USER, 1'b0);
    repeat (20) begin
      va  = $random(seed);
      rnd = $random(seed);
      send_cmd(rnd[0], va);
    end
  endtask

  task automatic test_hit_miss();
    set_ctrl(1'b1, mmu_pkg::PRIV_SUPERVISOR, 1'b1);
    tlb_fill(20'h12345, 22'h2ABCD, 1'b1, 1'b1, 1'b1);
    send_cmd(1'b0, 32'h1234_5678);
    send_cmd(1'b1, 32'h1234_5ABC);
    send_cmd(1'b0, 32'h5432_1000);
  endtask

  task automatic test_fault_table();
    mmu_pkg::priv_mode_e mode;
    mmu_pkg::vtag_t vt;
    tlb_flush();
    tlb_fill(20'h0A000, 22'h0B000, 1'b1, 1'b1, 1'b1);
    tlb_fill(20'h0A001, 22'h0B001, 1'b0, 1'b1, 1'b1);
    tlb_fill(20'h0A002, 22'h0B002, 1'b0, 1'b0, 1'b1);
    tlb_fill(20'h0A003, 22'h0B003, 1'b0, 1'b1, 1'b0);
    for (int m = 0; m < 3; m++) begin
      mode = (m == 0) ? mmu_pkg::PRIV_USER :
             (m == 1) ? mmu_pkg::PRIV_SUPERVISOR : mmu_pkg::PRIV_MACHINE;
      for (int s = 0; s < 2; s++) begin
        set_ctrl(1'b1, mode, s[0]);
        for (int p = 0; p < 4; p++) begin
          vt = mmu_pkg::vtag_t'(32'h0A000 + p);
          send_cmd(1'b0, {vt, 12'h010});
          send_cmd(1'b1, {vt, 12'h020});
        end
      end
    end
  endtask

  task automatic test_evict_flush();
    tlb_flush();
    set_ctrl(1'b1, mmu_pkg::PRIV_SUPERVISOR, 1'b1);
    // Ninth fill replaces the oldest of the first eight
    for (int i = 0; i < 9; i++) begin
      tlb_fill(mmu_pkg::vtag_t'(32'h100 + i), mmu_pkg::ptag_t'(32'h200 + i),
               1'b0, 1'b1, 1'b1);
    end
    for (int i = 0; i < 9; i++) begin
      send_cmd(1'b0, {mmu_pkg::vtag_t'(32'h100 + i), 12'hABC});
    end
    tlb_flush();
    for (int i = 0; i < 9; i++) begin
      send_cmd(1'b0, {mmu_pkg::vtag_t'(32'h100 + i), 12'hABC});
    end
  endtask

  task automatic test_back_to_back();
    mmu_pkg::vaddr_t b_va [4];
    mmu_pkg::paddr_t e_pa [4];
    logic [3:0] b_store;
    logic [3:0] b_kill;
    logic [3:0] e_miss;
    logic [3:0] e_lf;
    logic [3:0] e_sf;
    set_ctrl(1'b1, mmu_pkg::PRIV_SUPERVISOR, 1'b1);
    tlb_fill(20'h30000, 22'h10000, 1'b0, 1'b1, 1'b1);
    b_va[0] = 32'h3000_0111;
    b_va[1] = 32'h3000_0222;
    b_va[2] = 32'h4000_0333;
    b_va[3] = 32'h3000_0444;
    b_store = 4'b1000;
    b_kill  = 4'b0010;
    for (int i = 0; i < 4; i++) begin
      predict(b_store[i], b_va[i], e_miss[i], e_lf[i], e_sf[i], e_pa[i]);
    end
    // Command c enters in cycle c and its kill comes one cycle later
    for (int cyc = 0; cyc < 6; cyc++) begin
      if (cyc >= 2) begin
        check_resp(!b_kill[cyc-2], e_miss[cyc-2], e_lf[cyc-2], e_sf[cyc-2], e_pa[cyc-2]);
      end
      cmd_v_i = (cyc < 4);
      if (cyc < 4) begin
        cmd_store_i = b_store[cyc];
        cmd_vaddr_i = b_va[cyc];
      end
      kill_i = (cyc >= 1 && cyc <= 4) ? b_kill[cyc-1] : 1'b0;
      @(posedge clk_i);
      #1;
    end
    check_bit("resp_v_o", resp_v_o, 1'b0);
  endtask

  initial begin
    reset_i     = 1'b1;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    cmd_v_i     = 1'b0;
    cmd_store_i = 1'b0;
    cmd_vaddr_i = '0;
    kill_i      = 1'b0;
    model_en     = 1'b0;
    model_priv   = mmu_pkg::PRIV_USER;
    model_sum    = 1'b0;
    model_victim = 0;
    for (int i = 0; i < ENTRIES; i++) begin
      model_valid[i] = 1'b0;
    end
    repeat (5) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_bit("resp_v_o", resp_v_o, 1'b0);
    check_bit("pslverr_o", pslverr_o, 1'b0);

    test_registers();
    test_bypass();
    test_hit_miss();
    test_fault_table();
    test_evict_flush();
    test_back_to_back();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+include
rtl/mmu_pkg.sv
rtl/mmu_apb_regs.sv
rtl/mmu_cmd_stage.sv
rtl/mmu_tlb_entry.sv
rtl/mmu_resp_stage.sv
rtl/mmu_top.sv
testbench/mmu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the MMU testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
  -f project.f --top-module mmu_tb -o mmu_sim

./obj_dir/mmu_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

echo "Simulation finished, see sim.log"
exit 0
